// ==== build.f ====
+incdir+verification
hdl/conv_pad_pkg.sv
hdl/skew_bus_if.sv
hdl/col_tracker.sv
hdl/skew_line.sv
hdl/pad_filter.sv
hdl/mask_apply.sv
hdl/pad_mask_top.sv
verification/tb_pad_mask.sv

// ==== hdl/col_tracker.sv ====
/* counts channels and columns of the incoming beats, start is taken only while aclken is high
   and should come before the first beat of an image, cols_1 should be at least k2 */
`timescale 1ns/1ns

module col_tracker (
    input  logic                                     aclk,
    input  logic                                     aclken,
    input  logic                                     rst_n,
    input  logic                                     start,
    input  logic [conv_pad_pkg::col_width-1:0]       cols_1,
    input  logic [conv_pad_pkg::col_width-1:0]       chans_1,
    input  logic [conv_pad_pkg::kernel_w_width-1:0]  kernel_w_1,
    input  logic                                     s_valid,
    output logic                                     out_last,
    output conv_pad_pkg::pad_user_t                  out_user
);
    import conv_pad_pkg::*;

    logic [col_width-1:0] cols_1_reg;   // last column index of the image
    logic [col_width-1:0] chans_1_reg;  // last channel index of a column
    logic [col_width-1:0] col_k2_reg;   // column at which the end-of-image marker is raised
    logic                 is_1x1_reg;   // kernel width one, latched at start
    logic [col_width-1:0] col_cnt;      // column of the current beat
    logic [col_width-1:0] chan_cnt;     // channel of the current beat
    logic                 chan_wrap;    // current beat is the final channel
    logic                 col_wrap;     // current column is the final column

    assign chan_wrap = (chan_cnt == chans_1_reg);
    assign col_wrap  = (col_cnt == cols_1_reg);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cols_1_reg  <= '0;
            chans_1_reg <= '0;
            col_k2_reg  <= '0;
            is_1x1_reg  <= 1'b0;
            col_cnt     <= '0;
            chan_cnt    <= '0;
        end else if (aclken) begin
            if (start) begin
                cols_1_reg  <= cols_1;
                chans_1_reg <= chans_1;
                col_k2_reg  <= cols_1 - col_width'(kernel_w_1 >> 1); // cols_1 - k2
                is_1x1_reg  <= (kernel_w_1 == '0);
                col_cnt     <= '0;          // a new image always opens on column zero
                chan_cnt    <= '0;
            end else if (s_valid) begin
                if (chan_wrap) begin
                    chan_cnt <= '0;
                    col_cnt  <= col_wrap ? '0 : col_cnt + col_width'(1); // wraps into next image
                end else begin
                    chan_cnt <= chan_cnt + col_width'(1);
                end
            end
        end
    end

    // combinational so the beat, its last flag and its user bits stay aligned on tap 0
    assign out_last              = s_valid & chan_wrap;
    assign out_user.is_cols_1_k2 = (col_cnt == col_k2_reg);
    assign out_user.is_1x1       = is_1x1_reg;

endmodule

// ==== hdl/conv_pad_pkg.sv ====
/* shared widths and types of the horizontal padding stage, kernel widths are odd and at most
   kernel_w_max, and the top must be built with KERNEL_W_MAX and DATA_WIDTH equal to these */
package conv_pad_pkg;

    parameter int kernel_w_max   = 7;                       // widest odd kernel, also the datapath count
    parameter int kw2_max        = kernel_w_max / 2;        // depth of the column shift registers
    parameter int kernel_w_width = $clog2(kernel_w_max + 1); // holds kernel width minus one
    parameter int data_width     = 16;                      // one partial sum
    parameter int col_width      = 10;                      // column and channel counters

    // side-band bits that ride along with every beat
    typedef struct packed {
        logic is_cols_1_k2; // beat belongs to column cols_1 - k2
        logic is_1x1;       // kernel is a single column, nothing is padded
    } pad_user_t;

    typedef logic [data_width-1:0] psum_t; // one partial sum of one datapath

    // kernel width minus one in, lookup index (k2 - 1) out
    // 3 -> 0, 5 -> 1, 7 -> 2, a 1x1 kernel wraps to all ones and selects no table row
    function automatic logic [kernel_w_width-1:0] kw2_index(
        input logic [kernel_w_width-1:0] kw_1
    );
        logic [kernel_w_width-1:0] half;
        half = kw_1 >> 1;                       // k2, since kw - 1 = 2 * k2
        return half - kernel_w_width'(1);
    endfunction

endpackage

// ==== hdl/mask_apply.sv ====
/* output register of the padding stage, sums outside the full mask leave as zero and the
   two masks are only raised on valid beats */
`timescale 1ns/1ns

module mask_apply #(
    parameter int KERNEL_W_MAX = conv_pad_pkg::kernel_w_max
) (
    input  logic                aclk,
    input  logic                aclken,
    input  logic                rst_n,
    skew_bus_if.sink            bus,
    input  logic                mask_full    [KERNEL_W_MAX-1:0],
    input  logic                mask_partial [KERNEL_W_MAX-1:1],
    output logic                m_valid      [KERNEL_W_MAX-1:0],
    output conv_pad_pkg::psum_t m_data       [KERNEL_W_MAX-1:0],
    output logic                m_full       [KERNEL_W_MAX-1:0],
    output logic                m_partial    [KERNEL_W_MAX-1:1]
);
    import conv_pad_pkg::*;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                m_valid[i] <= 1'b0;
                m_full[i]  <= 1'b0;
            end
            for (int i = 1; i < KERNEL_W_MAX; i++) begin
                m_partial[i] <= 1'b0;
            end
        end else if (aclken) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                m_valid[i] <= bus.valid[i];
                m_full[i]  <= bus.valid[i] & mask_full[i];  // idle cycles report no mask
            end
            for (int i = 1; i < KERNEL_W_MAX; i++) begin
                m_partial[i] <= bus.valid[i] & mask_partial[i];
            end
        end
    end

    // data path, m_valid tells when it is meaningful
    always_ff @(posedge aclk) begin
        if (aclken) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                m_data[i] <= mask_full[i] ? bus.data[i] : psum_t'(0); // padding reads as zero
            end
        end
    end

endmodule

// ==== hdl/pad_filter.sv ====
/* full and partial padding masks for every datapath, the kernel width is latched at start and
   start also rearms the column state so the first k2 columns of the next image are blocked */
`timescale 1ns/1ns

module pad_filter #(
    parameter int KERNEL_W_MAX = conv_pad_pkg::kernel_w_max,
    parameter int DATA_WIDTH   = conv_pad_pkg::data_width
) (
    input  logic                                    aclk,
    input  logic                                    aclken,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic [conv_pad_pkg::kernel_w_width-1:0] kernel_w_1,
    skew_bus_if.sink                                bus,
    output logic                                    mask_full    [KERNEL_W_MAX-1:0],
    output logic                                    mask_partial [KERNEL_W_MAX-1:1]
);
    import conv_pad_pkg::*;

    localparam int SEL_W = (kw2_max > 1) ? $clog2(kw2_max) : 1; // width of a table row index

    // the column registers are sized from the package, so the top must agree with it
    if (KERNEL_W_MAX / 2 != kw2_max || DATA_WIDTH != data_width) begin : g_param_check
        $error("pad_filter parameters differ from conv_pad_pkg");
    end

    logic [kernel_w_width-1:0] kw2_reg;   // k2 - 1 of the running kernel, 1 after reset
    logic [SEL_W-1:0]          kw_sel;    // row of the lookup tables in use
    logic [kw2_max-1:0]        col_end   [KERNEL_W_MAX-1:0]; // marker walking towards the last column
    logic [kw2_max-1:0]        col_start [KERNEL_W_MAX-1:0]; // marker walking through the first columns
    logic                      lut_allow_full   [KERNEL_W_MAX-1:0][kw2_max-1:0];
    logic                      lut_stop_partial [KERNEL_W_MAX-1:1][kw2_max-1:0];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            kw2_reg <= kernel_w_width'(1);
        end else if (aclken && start) begin
            kw2_reg <= kw2_index(kernel_w_1);
        end
    end

    // a 1x1 kernel has no row of its own, row 0 stands in and is_1x1 overrides the result
    assign kw_sel = (kw2_reg < kernel_w_width'(kw2_max)) ? SEL_W'(kw2_reg) : '0;

    /* for kernel 5 the end marker enters on column cols_1-2, sits in bit 1 on the last column,
       then moves into col_start bit 0 for column 0 and bit 1 for column 1 */
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                col_end[i]   <= '0;
                col_start[i] <= '0;
            end
        end else if (aclken) begin
            for (int i = 0; i < KERNEL_W_MAX; i++) begin
                if (start) begin
                    col_end[i]   <= '0;
                    col_start[i] <= kw2_max'(1);  // as if a last column had just closed
                end else if (bus.last[i]) begin
                    col_end[i]   <= (col_end[i] << 1)
                                  | kw2_max'(bus.user[i].is_cols_1_k2);
                    col_start[i] <= (col_start[i] << 1)
                                  | kw2_max'(col_end[i][kw_sel]); // leaves at the last column
                end
            end
        end
    end

    // full mask, one table row per odd kernel, row r is kernel 2r+3
    for (genvar i = 0; i < KERNEL_W_MAX; i++) begin : g_full_dp
        for (genvar r = 0; r < kw2_max; r++) begin : g_full_kw
            localparam bit FULL_DP  = (i == 2 * (r + 1));   // datapath kw-1 holds a whole window
            localparam bit UNUSED   = (i > 2 * (r + 1));    // beyond the kernel, never valid
            localparam bit PARTIAL  = (i > r);              // at least k2 columns summed in

            logic start_cols;                               // within the first k2 columns
            logic last_col;                                 // on the last column of the image

            assign start_cols = |col_start[i][r:0];
            assign last_col   = col_end[i][r];

            assign lut_allow_full[i][r] = (FULL_DP & ~start_cols)
                                        | (last_col & PARTIAL & ~UNUSED);
        end

        assign mask_full[i] = bus.user[i].is_1x1 | lut_allow_full[i][kw_sel];
    end

    // partial mask, datapath 0 never carries a partial window so the table starts at 1
    for (genvar i = 1; i < KERNEL_W_MAX; i++) begin : g_part_dp
        for (genvar r = 0; r < kw2_max; r++) begin : g_part_kw
            if (r < i - 1) begin : g_always_stop
                assign lut_stop_partial[i][r] = 1'b1;   // above the blocking triangle
            end else begin : g_triangle
                // stop once the end marker has reached bits i-1 .. k2-1
                assign lut_stop_partial[i][r] = |col_end[i][r:i-1];
            end
        end

        assign mask_partial[i] = ~bus.user[i].is_1x1 & ~lut_stop_partial[i][kw_sel];
    end

endmodule

// ==== hdl/pad_mask_top.sv ====
/* horizontal zero padding for same-size convolution, no back-pressure, aclken freezes the whole
   stage, datapath i of the outputs follows the input beat by i+1 enabled cycles */
`timescale 1ns/1ns

module pad_mask_top #(
    parameter int KERNEL_W_MAX = conv_pad_pkg::kernel_w_max,
    parameter int DATA_WIDTH   = conv_pad_pkg::data_width
) (
    input  logic                                    aclk,
    input  logic                                    aclken,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic [conv_pad_pkg::kernel_w_width-1:0] kernel_w_1,
    input  logic [conv_pad_pkg::col_width-1:0]      cols_1,
    input  logic [conv_pad_pkg::col_width-1:0]      chans_1,
    input  logic                                    s_valid,
    input  conv_pad_pkg::psum_t                     s_data    [KERNEL_W_MAX-1:0],
    output logic                                    m_valid   [KERNEL_W_MAX-1:0],
    output conv_pad_pkg::psum_t                     m_data    [KERNEL_W_MAX-1:0],
    output logic                                    m_full    [KERNEL_W_MAX-1:0],
    output logic                                    m_partial [KERNEL_W_MAX-1:1]
);
    import conv_pad_pkg::*;

    // control that travels through the skew next to the sums
    typedef struct packed {
        logic      valid;
        logic      last;
        pad_user_t user;
    } ctl_beat_t;

    typedef psum_t [KERNEL_W_MAX-1:0] psum_vec_t; // all sums of one beat

    logic      trk_last;                            // final channel strobe from the tracker
    pad_user_t trk_user;                            // user bits of the current beat
    ctl_beat_t ctl_d;
    ctl_beat_t ctl_q        [KERNEL_W_MAX-1:0];
    psum_vec_t data_d;
    psum_vec_t data_q       [KERNEL_W_MAX-1:0];     // datapath i keeps only lane i of its tap
    logic      mask_full    [KERNEL_W_MAX-1:0];
    logic      mask_partial [KERNEL_W_MAX-1:1];

    skew_bus_if #(.KERNEL_W_MAX(KERNEL_W_MAX)) bus ();

    col_tracker u_col_tracker (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .start(start),
        .cols_1(cols_1), .chans_1(chans_1), .kernel_w_1(kernel_w_1),
        .s_valid(s_valid), .out_last(trk_last), .out_user(trk_user)
    );

    assign ctl_d.valid = s_valid;
    assign ctl_d.last  = trk_last;
    assign ctl_d.user  = trk_user;

    skew_line #(.T(ctl_beat_t), .KERNEL_W_MAX(KERNEL_W_MAX)) u_skew_ctl (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .d(ctl_d), .q(ctl_q)
    );

    skew_line #(.T(psum_vec_t), .KERNEL_W_MAX(KERNEL_W_MAX)) u_skew_data (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .d(data_d), .q(data_q)
    );

    for (genvar i = 0; i < KERNEL_W_MAX; i++) begin : g_bus
        assign data_d[i]     = s_data[i];
        assign bus.valid[i]  = ctl_q[i].valid;
        assign bus.last[i]   = ctl_q[i].last;
        assign bus.user[i]   = ctl_q[i].user;
        assign bus.data[i]   = data_q[i][i];    // lane i delayed by i beats
    end

    pad_filter #(.KERNEL_W_MAX(KERNEL_W_MAX), .DATA_WIDTH(DATA_WIDTH)) u_pad_filter (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .start(start),
        .kernel_w_1(kernel_w_1), .bus(bus),
        .mask_full(mask_full), .mask_partial(mask_partial)
    );

    mask_apply #(.KERNEL_W_MAX(KERNEL_W_MAX)) u_mask_apply (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .bus(bus),
        .mask_full(mask_full), .mask_partial(mask_partial),
        .m_valid(m_valid), .m_data(m_data), .m_full(m_full), .m_partial(m_partial)
    );

endmodule

// ==== hdl/skew_bus_if.sv ====
/* per-datapath beat after the skew lines, entry i is the beat as datapath i sees it */
`timescale 1ns/1ns

interface skew_bus_if #(
    parameter int KERNEL_W_MAX = conv_pad_pkg::kernel_w_max
) ();
    import conv_pad_pkg::*;

    logic      valid [KERNEL_W_MAX-1:0]; // beat present on this datapath
    logic      last  [KERNEL_W_MAX-1:0]; // valid beat that closes a column
    pad_user_t user  [KERNEL_W_MAX-1:0]; // side-band bits built by the column tracker
    psum_t     data  [KERNEL_W_MAX-1:0]; // partial sum of this datapath

    // driven by the two skew lines
    modport source (
        output valid,
        output last,
        output user,
        output data
    );

    // read by the mask logic and the output register
    modport sink (
        input valid,
        input last,
        input user,
        input data
    );

endinterface

// ==== hdl/skew_line.sv ====
/* staggered delay line, tap i holds the input delayed by i enabled cycles and tap 0 is the
   input itself, every stage holds while aclken is low */
`timescale 1ns/1ns

module skew_line #(
    parameter type T            = logic,
    parameter int  KERNEL_W_MAX = 7
) (
    input  logic aclk,
    input  logic aclken,
    input  logic rst_n,
    input  T     d,
    output T     q [KERNEL_W_MAX-1:0]
);

    T stage [KERNEL_W_MAX-1:1]; // stage k is k enabled cycles behind d

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < KERNEL_W_MAX; k++) begin
                stage[k] <= '0;                 // clears the valid bits riding in T
            end
        end else if (aclken) begin
            stage[1] <= d;
            for (int k = 2; k < KERNEL_W_MAX; k++) begin
                stage[k] <= stage[k-1];         // one more beat of skew per datapath
            end
        end
    end

    assign q[0] = d; // datapath 0 sees the beat with no delay

    for (genvar i = 1; i < KERNEL_W_MAX; i++) begin : g_tap
        assign q[i] = stage[i];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compiles the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_pad_mask -f build.f -o sim_pad_mask
out=$(./obj_dir/sim_pad_mask)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Test passed'; then
    exit 0
fi
exit 1

// ==== verification/pad_ref.svh ====
/* expected masks and data of one output beat, kernel widths are odd, cols_1 is at least k2
   and every image begins with a start */
`ifndef PAD_REF_SVH
`define PAD_REF_SVH

typedef struct packed {
    logic  full;    // sum lies fully inside the image
    logic  partial; // sum still carries a partial window
    psum_t data;    // sum after zero padding
} pad_exp_t;

// dp is the datapath, col the column of the beat, kw the kernel width, sum the lane dp input
function automatic pad_exp_t expect_beat(input int dp, input int col, input int cols_1,
                                         input int kw, input psum_t sum);
    pad_exp_t want;
    int       k2;
    k2 = kw / 2;
    if (kw == 1) begin
        want.full    = 1'b1;            // a single column kernel never reaches the padding
        want.partial = 1'b0;
    end else begin
        // the widest datapath holds a whole window once the first k2 columns are past
        want.full = ((dp == kw - 1) && (col >= k2))
                  || ((col == cols_1) && (dp >= k2) && (dp <= kw - 1)); // last column closes
        // datapaths 1 to k2 stay partial until the end of the image reaches them
        want.partial = (dp >= 1) && (dp <= k2) && (col < cols_1 - k2 + dp);
    end
    want.data = want.full ? sum : psum_t'(0);
    return want;
endfunction

`endif

// ==== verification/tb_pad_mask.sv ====
/* testbench of the horizontal padding stage, every image uses an odd kernel with cols_1 >= k2,
   the stall test drops aclken on about one cycle in four */
`timescale 1ns/1ns

module tb_pad_mask;
    import conv_pad_pkg::*;
    `include "pad_ref.svh"

    localparam int KW          = kernel_w_max;
    localparam int CLK_NS      = 4;
    localparam int MAX_BEATS   = 64;
    localparam int TOTAL_BEATS = 4 * 24 + 12 + 14;    // input beats over all tests
    localparam int N_TESTS     = 6;
    localparam int SETTLE      = 24;                  // start, drain and idle cycles per test
    localparam int WATCHDOG_NS = 2 * CLK_NS * (2 * TOTAL_BEATS + N_TESTS * SETTLE);

    logic                      aclk = 1'b0;
    logic                      aclken;
    logic                      rst_n;
    logic                      start;
    logic [kernel_w_width-1:0] kernel_w_1;
    logic [col_width-1:0]      cols_1;
    logic [col_width-1:0]      chans_1;
    logic                      s_valid;
    psum_t                     s_data    [KW-1:0];
    logic                      m_valid   [KW-1:0];
    psum_t                     m_data    [KW-1:0];
    logic                      m_full    [KW-1:0];
    logic                      m_partial [KW-1:1];

    int    seed = 72;                  // fixed seed for sums and stalls
    bit    stall_on;                   // random aclken drops while set
    int    cur_kw;                     // kernel width of the running image
    int    cur_cols_1;
    int    cur_chans_1;
    int    in_cnt;                     // beats taken by the DUT in this image
    int    in_col   [MAX_BEATS];       // column of each taken beat
    int    in_edge  [MAX_BEATS];       // enabled edge that took the beat
    psum_t in_lanes [MAX_BEATS][KW];   // sums of each taken beat
    int    out_cnt  [KW];              // output beats seen per datapath
    int    en_edges;                   // enabled edges since reset
    bit    en_last;                    // the latest edge updated the DUT registers
    int    checks;
    int    errors;
    int    test_errors;
    int    tests;

    pad_mask_top DUT (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .start(start),
        .kernel_w_1(kernel_w_1), .cols_1(cols_1), .chans_1(chans_1),
        .s_valid(s_valid), .s_data(s_data),
        .m_valid(m_valid), .m_data(m_data), .m_full(m_full), .m_partial(m_partial)
    );

    always #(CLK_NS / 2) aclk = ~aclk;

    task automatic check_bit(input string name, input int dp, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("FAIL %s[%0d] got %h expected %h at %0t", name, dp, got, want, $time);
        end
    endtask

    task automatic check_psum(input string name, input int dp, input psum_t got, input psum_t want);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("FAIL %s[%0d] got %h expected %h at %0t", name, dp, got, want, $time);
        end
    endtask

    function automatic logic pick_enable();
        if (!stall_on) begin
            return 1'b1;
        end
        return ($random(seed) & 3) != 0;
    endfunction

    // called after a rising edge, start is taken on the next one with aclken high
    task automatic start_image(input int kw, input int c1, input int ch1);
        in_cnt      = 0;
        cur_kw      = kw;
        cur_cols_1  = c1;
        cur_chans_1 = ch1;
        for (int i = 0; i < KW; i++) begin
            out_cnt[i] = 0;
        end
        kernel_w_1 <= kernel_w_width'(kw - 1);
        cols_1     <= col_width'(c1);
        chans_1    <= col_width'(ch1);
        start      <= 1'b1;
        aclken     <= 1'b1;
        s_valid    <= 1'b0;
        @(posedge aclk);
        start      <= 1'b0;
    endtask

    // holds one beat until an edge with aclken high has taken it
    task automatic drive_beat();
        s_valid <= 1'b1;
        for (int i = 0; i < KW; i++) begin
            s_data[i] <= psum_t'($random(seed));
        end
        aclken <= pick_enable();
        @(posedge aclk);
        while (!aclken) begin
            aclken <= pick_enable();
            @(posedge aclk);
        end
    endtask

    task automatic feed_image(input int beats);
        for (int b = 0; b < beats; b++) begin
            drive_beat();
        end
        s_valid <= 1'b0;
        aclken  <= 1'b1;                               // the skew drains only while enabled
    endtask

    task automatic wait_drain(input int beats);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge aclk);
            done = 1'b1;
            for (int i = 0; i < KW; i++) begin
                if (out_cnt[i] < beats) begin
                    done = 1'b0;
                end
            end
        end
        repeat (3) @(posedge aclk);                    // a stray m_valid would show up here
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, test_errors);
        test_errors = 0;
    endtask

    // input monitor, reads what the DUT samples on this edge
    always @(posedge aclk) begin
        en_last = aclken && rst_n;
        if (en_last) begin
            en_edges++;
            if (s_valid && !start && in_cnt < MAX_BEATS) begin
                in_edge[in_cnt] = en_edges;
                in_col[in_cnt]  = (in_cnt / (cur_chans_1 + 1)) % (cur_cols_1 + 1);
                for (int i = 0; i < KW; i++) begin
                    in_lanes[in_cnt][i] = s_data[i];
                end
                in_cnt++;
            end
        end
    end

    // scoreboard, outputs are stable at the falling edge
    always @(negedge aclk) begin
        pad_exp_t want;
        int       n;
        if (rst_n && en_last) begin
            for (int i = 0; i < KW; i++) begin
                if (m_valid[i]) begin
                    n = out_cnt[i];
                    out_cnt[i]++;
                    if (n >= in_cnt) begin
                        errors++;
                        test_errors++;
                        $display("datapath %0d raised m_valid with no input beat left at %0t",
                                 i, $time);
                    end else begin
                        want = expect_beat(i, in_col[n], cur_cols_1, cur_kw, in_lanes[n][i]);
                        check_bit("m_full", i, m_full[i], want.full);
                        if (i > 0) begin
                            check_bit("m_partial", i, m_partial[i], want.partial);
                        end
                        check_psum("m_data", i, m_data[i], want.data);
                        checks++;
                        // s_valid is driven one edge before it is taken, hence i+1 cycles
                        if (en_edges != in_edge[n] + i) begin
                            errors++;
                            test_errors++;
                            $display("datapath %0d beat %0d came after %0d enabled cycles, not %0d",
                                     i, n, en_edges - in_edge[n] + 1, i + 1);
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the outputs never drained", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        aclken     = 1'b1;
        rst_n      = 1'b0;
        start      = 1'b0;
        kernel_w_1 = '0;
        cols_1     = '0;
        chans_1    = '0;
        s_valid    = 1'b0;
        stall_on   = 1'b0;
        for (int i = 0; i < KW; i++) begin
            s_data[i] = '0;
        end
        repeat (4) @(posedge aclk);
        rst_n <= 1'b1;

        repeat (3) begin
            @(negedge aclk);
            for (int i = 0; i < KW; i++) begin
                check_bit("m_valid", i, m_valid[i], 1'b0);
                check_bit("m_full", i, m_full[i], 1'b0);
            end
            for (int i = 1; i < KW; i++) begin
                check_bit("m_partial", i, m_partial[i], 1'b0);
            end
        end
        @(posedge aclk);
        finish_test("idle after reset");

        start_image(3, 7, 2);
        feed_image(24);
        wait_drain(24);
        finish_test("kernel 3");

        start_image(7, 7, 2);
        feed_image(24);
        wait_drain(24);
        finish_test("kernel 7");

        start_image(1, 7, 2);
        feed_image(24);
        wait_drain(24);
        finish_test("kernel 1");

        stall_on = 1'b1;
        start_image(7, 7, 2);
        feed_image(24);
        wait_drain(24);
        stall_on = 1'b0;
        finish_test("kernel 7 with stalls");

        start_image(3, 7, 2);                          // image cut off after four columns
        feed_image(12);
        wait_drain(12);
        start_image(5, 6, 1);
        feed_image(14);
        wait_drain(14);
        finish_test("restart with kernel 5");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
